// ==== design/mem_pkg.sv ====
/*
 * Shared sizes and types for the SRAM subsystem.
 * mem_depth must be a power of two, since the BIST address counter wraps.
 * mem_dw must be a multiple of 8 for the Wishbone byte selects.
 */

package mem_pkg;

   //##########################################################################
   // sizes
   //##########################################################################

   localparam int mem_dw    = 32;                 // data width
   localparam int mem_depth = 256;                // words in the array
   localparam int mem_aw    = $clog2(mem_depth);  // word address width
   localparam int mem_sel_w = mem_dw / 8;         // byte selects per word

   //##########################################################################
   // types
   //##########################################################################

   // one access into the single-port memory
   typedef struct packed {
      logic              en;    // access valid
      logic              we;    // write, else read
      logic [mem_dw-1:0] wem;   // per-bit write enable
      logic [mem_aw-1:0] addr;  // word address
      logic [mem_dw-1:0] din;   // write data
   } mem_req_t;

   // march test phases, in run order
   typedef enum logic [2:0] {
      idle    = 3'd0,  // waiting for start
      w0_up   = 3'd1,  // write 0, ascending
      r0w1_up = 3'd2,  // read 0 then write 1, ascending
      r1w0_dn = 3'd3,  // read 1 then write 0, descending
      r0_up   = 3'd4,  // read 0, ascending
      done    = 3'd5   // drain last compare
   } bist_state_t;

endpackage

// ==== design/mem_ram.sv ====
/*
 * Behavioral single-port storage array.
 * Read-before-write: every access registers the old word at its address,
 * so a write also returns the prior contents one cycle later.
 * Array contents are not reset, only the read register is.
 */

`timescale 1ns/1ps

module mem_ram
   import mem_pkg::*;
(
   input  logic              clk,      // memory clock
   input  logic              rst_n,    // async reset, active low
   input  mem_req_t          req,      // access from the wrapper
   output logic [mem_dw-1:0] rd_data   // registered read word
);

   //##########################################################################
   // storage
   //##########################################################################

   logic [mem_dw-1:0] ram [mem_depth];  // the array itself
   logic [mem_dw-1:0] rd_q;             // read output register
   logic              wr;               // write strobe

   assign wr = req.en & req.we;  // only enabled writes touch the array

   // masked write, bits with wem low keep their value
   always_ff @(posedge clk) begin
      if (wr) begin
         ram[req.addr] <= (ram[req.addr] & ~req.wem) | (req.din & req.wem);
      end
   end

   //##########################################################################
   // read port
   //##########################################################################

   // old word captured on any access, held while idle
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_q <= '0;                // clean output after reset
      end else if (req.en) begin
         rd_q <= ram[req.addr];     // read-first
      end
   end

   assign rd_data = rd_q;  // valid the cycle after the access

endmodule

// ==== design/mem_sp.sv ====
/*
 * Single-port memory wrapper with a BIST side port.
 * BIST owns the port while bist_active is high; bus requests are ignored.
 * shutdown blocks every access; the array keeps its contents and reads
 * issued under shutdown return zero. No latency is added over mem_ram.
 */

`timescale 1ns/1ps

module mem_sp
   import mem_pkg::*;
(
   input  logic              clk,          // memory clock
   input  logic              rst_n,        // async reset, active low
   input  mem_req_t          bus_req,      // request from the bus slave
   input  mem_req_t          bist_req,     // request from the BIST engine
   input  logic              bist_active,  // BIST owns the port
   input  logic              shutdown,     // from the always-on domain
   output logic [mem_dw-1:0] rd_data       // read word, zero under shutdown
);

   //##########################################################################
   // request select and gating
   //##########################################################################

   mem_req_t          sel_req;  // winner of the two sources
   mem_req_t          ram_req;  // what the array actually sees
   logic [mem_dw-1:0] ram_rd;   // raw array output
   logic              sd_q;     // shutdown seen by the last access

   always_comb begin
      sel_req    = bist_active ? bist_req : bus_req;  // BIST has priority
      ram_req    = sel_req;
      ram_req.en = sel_req.en & ~shutdown;            // no access while off
   end

   //##########################################################################
   // read data masking
   //##########################################################################

   // tracks shutdown per access so it lines up with the registered read
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sd_q <= 1'b0;
      end else if (sel_req.en) begin
         sd_q <= shutdown;  // held between accesses like the read word
      end
   end

   // array output stays stale under shutdown, so force zero instead
   assign rd_data = sd_q ? '0 : ram_rd;

   //##########################################################################
   // storage
   //##########################################################################

   mem_ram mem_ram_inst (
      .clk     (clk),
      .rst_n   (rst_n),
      .req     (ram_req),
      .rd_data (ram_rd)
   );

endmodule

// ==== design/mem_bist.sv ====
/*
 * March C- style BIST: w0 up, r0w1 up, r1w0 down, r0 up.
 * One access per cycle; read checks rely on the read-before-write array.
 * A run takes 4 * mem_depth + 2 cycles from the start edge to done.
 * The run overwrites the whole array and leaves it all zero.
 */

`timescale 1ns/1ps

module mem_bist
   import mem_pkg::*;
(
   input  logic              clk,       // memory clock
   input  logic              rst_n,     // async reset, active low
   input  logic              start,     // sampled only in idle
   input  logic [mem_dw-1:0] rd_data,   // read word from the wrapper
   output mem_req_t          bist_req,  // access toward the wrapper
   output logic              active,    // owns the memory port
   output logic              done,      // one-cycle end-of-run pulse
   output logic              fail       // sticky mismatch flag
);

   localparam logic [mem_aw-1:0] addr_max = mem_aw'(mem_depth - 1);  // top word

   bist_state_t       state_q;   // march phase
   logic [mem_aw-1:0] addr_q;    // up/down address counter
   logic              done_q;    // end pulse
   logic              fail_q;    // sticky fail
   logic              chk_v_q;   // a read is due back this cycle
   logic [mem_dw-1:0] chk_exp_q; // its expected value
   logic              is_rd;     // current access carries a check
   logic [mem_dw-1:0] exp_word;  // expected old word at current address

   //##########################################################################
   // request decode
   //##########################################################################

   always_comb begin
      bist_req      = '0;       // idle and drain issue nothing
      bist_req.wem  = '1;       // BIST always writes full words
      bist_req.addr = addr_q;
      is_rd         = 1'b0;
      exp_word      = '0;
      case (state_q)
         w0_up: begin
            bist_req.en  = 1'b1;
            bist_req.we  = 1'b1;   // din stays zero
         end
         r0w1_up: begin
            bist_req.en  = 1'b1;
            bist_req.we  = 1'b1;
            bist_req.din = '1;     // old word must be 0
            is_rd        = 1'b1;
         end
         r1w0_dn: begin
            bist_req.en  = 1'b1;
            bist_req.we  = 1'b1;   // back to zero
            is_rd        = 1'b1;
            exp_word     = '1;     // old word must be all ones
         end
         r0_up: begin
            bist_req.en  = 1'b1;   // plain read
            is_rd        = 1'b1;
         end
         default: ;
      endcase
   end

   //##########################################################################
   // phase sequencer
   //##########################################################################

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= idle;
         addr_q  <= '0;
         done_q  <= 1'b0;
         fail_q  <= 1'b0;
         chk_v_q <= 1'b0;
      end else begin
         done_q  <= 1'b0;                    // pulse by default
         chk_v_q <= is_rd;                   // read returns next cycle
         if (chk_v_q && (rd_data != chk_exp_q)) begin
            fail_q <= 1'b1;                  // sticky until next start
         end
         case (state_q)
            idle: begin
               if (start) begin
                  state_q <= w0_up;
                  addr_q  <= '0;
                  fail_q  <= 1'b0;           // fresh run
               end
            end
            w0_up: begin
               addr_q <= addr_q + 1'b1;      // wraps to 0 for next phase
               if (addr_q == addr_max) state_q <= r0w1_up;
            end
            r0w1_up: begin
               if (addr_q == addr_max) state_q <= r1w0_dn;  // descend from top
               else addr_q <= addr_q + 1'b1;
            end
            r1w0_dn: begin
               if (addr_q == '0) state_q <= r0_up;          // ascend from bottom
               else addr_q <= addr_q - 1'b1;
            end
            r0_up: begin
               addr_q <= addr_q + 1'b1;
               if (addr_q == addr_max) state_q <= mem_pkg::done;
            end
            mem_pkg::done: begin
               if (!chk_v_q) begin           // last compare has landed
                  state_q <= idle;
                  done_q  <= 1'b1;
               end
            end
            default: state_q <= idle;
         endcase
      end
   end

   // expected value follows the read by one cycle
   always_ff @(posedge clk) begin
      chk_exp_q <= exp_word;
   end

   assign active = (state_q != idle);  // port held through the drain cycle
   assign done   = done_q;
   assign fail   = fail_q;

endmodule

// ==== design/wb_mem_slave.sv ====
/*
 * Wishbone classic slave onto the single-port memory.
 * Host must hold cyc/stb and the request until ack, one access per cycle.
 * ack comes 2 cycles after stb is sampled; longer while BIST is running.
 * dat_r is only meaningful for reads in the ack cycle.
 */

`timescale 1ns/1ps

module wb_mem_slave
   import mem_pkg::*;
(
   input  logic                 clk,          // bus clock, same as memory
   input  logic                 rst_n,        // async reset, active low
   input  logic                 cyc,          // bus cycle
   input  logic                 stb,          // strobe
   input  logic                 we,           // write
   input  logic [mem_aw-1:0]    adr,          // word address
   input  logic [mem_sel_w-1:0] sel,          // byte selects
   input  logic [mem_dw-1:0]    dat_w,        // write data
   output logic [mem_dw-1:0]    dat_r,        // read data
   output logic                 ack,          // registered ack
   input  logic                 bist_active,  // memory busy with BIST
   output mem_req_t             req,          // request to the wrapper
   input  logic [mem_dw-1:0]    rd_data       // read word from the wrapper
);

   logic [mem_dw-1:0] wem_exp;  // byte selects widened to bits
   logic              issue;    // accept the bus request this edge
   logic              req_en_q; // request presented to memory
   logic              pend_q;   // bus cycle taken, not yet finished
   logic              ack_q;    // ack register
   logic              we_q;     // payload
   logic [mem_dw-1:0] wem_q;
   logic [mem_aw-1:0] addr_q;
   logic [mem_dw-1:0] din_q;

   //##########################################################################
   // request capture
   //##########################################################################

   always_comb begin
      for (int i = 0; i < mem_sel_w; i++) begin
         wem_exp[i*8 +: 8] = {8{sel[i]}};  // one select per byte lane
      end
   end

   assign issue = cyc & stb & ~pend_q & ~bist_active;

   always_ff @(posedge clk) begin
      if (issue) begin
         we_q   <= we;
         wem_q  <= wem_exp;
         addr_q <= adr;
         din_q  <= dat_w;
      end
   end

   //##########################################################################
   // handshake
   //##########################################################################

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         req_en_q <= 1'b0;
         pend_q   <= 1'b0;
         ack_q    <= 1'b0;
      end else begin
         ack_q <= 1'b0;                           // single-cycle ack
         if (issue) begin
            req_en_q <= 1'b1;
            pend_q   <= 1'b1;                     // block a second issue
         end else if (req_en_q && !bist_active) begin
            req_en_q <= 1'b0;                     // memory took it this edge
            ack_q    <= 1'b1;
         end                                      // else held behind BIST
         if (ack_q) pend_q <= 1'b0;               // host moves on after ack
      end
   end

   assign req   = '{en: req_en_q, we: we_q, wem: wem_q, addr: addr_q, din: din_q};
   assign ack   = ack_q;
   assign dat_r = rd_data;  // array read lands in the ack cycle

endmodule

// ==== design/mem_subsys_top.sv ====
/*
 * SRAM subsystem top: Wishbone slave, BIST engine, single-port memory.
 * Bus cycles stall without ack while a BIST run is active.
 * shutdown gates all accesses and zeroes read data.
 */

`timescale 1ns/1ps

module mem_subsys_top
   import mem_pkg::*;
(
   input  logic                 clk,         // single clock domain
   input  logic                 rst_n,       // async reset, active low
   // wishbone classic host port
   input  logic                 cyc,
   input  logic                 stb,
   input  logic                 we,
   input  logic [mem_aw-1:0]    adr,         // word address
   input  logic [mem_sel_w-1:0] sel,
   input  logic [mem_dw-1:0]    dat_w,
   output logic [mem_dw-1:0]    dat_r,
   output logic                 ack,
   // test and power control
   input  logic                 start_bist,  // kick a march run
   input  logic                 shutdown,    // from always-on domain
   output logic                 bist_done,   // end-of-run pulse
   output logic                 bist_fail    // sticky mismatch
);

   mem_req_t          bus_req;      // slave to wrapper
   mem_req_t          bist_req;     // BIST to wrapper
   logic              bist_active;  // BIST owns the port
   logic [mem_dw-1:0] rd_data;      // shared read return

   wb_mem_slave wb_mem_slave_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .cyc         (cyc),
      .stb         (stb),
      .we          (we),
      .adr         (adr),
      .sel         (sel),
      .dat_w       (dat_w),
      .dat_r       (dat_r),
      .ack         (ack),
      .bist_active (bist_active),
      .req         (bus_req),
      .rd_data     (rd_data)
   );

   mem_bist mem_bist_inst (
      .clk      (clk),
      .rst_n    (rst_n),
      .start    (start_bist),
      .rd_data  (rd_data),
      .bist_req (bist_req),
      .active   (bist_active),
      .done     (bist_done),
      .fail     (bist_fail)
   );

   mem_sp mem_sp_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .bus_req     (bus_req),
      .bist_req    (bist_req),
      .bist_active (bist_active),
      .shutdown    (shutdown),
      .rd_data     (rd_data)
   );

endmodule

// ==== tests/tb_tasks.svh ====
/*
 * Testbench helpers, included inside the body of tb_mem_subsys.
 * Bus tasks drive 1 ns after the rising edge and hold the request until ack.
 * The shadow array is only valid for words written since the last BIST run.
 */

`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// galois lfsr, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
   logic [31:0] v;
   v = '0;
   for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v    = {v[30:0], lfsr[0]};  // lsb is the new bit
   end
   return v;
endfunction

// byte-select rule, one sel bit per byte lane
function automatic void shadow_write(input logic [mem_aw-1:0] a,
                                     input logic [mem_sel_w-1:0] s,
                                     input logic [mem_dw-1:0] d);
   for (int i = 0; i < mem_sel_w; i++) begin
      if (s[i]) shadow[a][i*8 +: 8] = d[i*8 +: 8];
   end
endfunction

// one wishbone classic cycle, held until ack
task automatic bus_cycle(input logic wr, input logic [mem_aw-1:0] a,
                         input logic [mem_sel_w-1:0] s, input logic [mem_dw-1:0] d,
                         input logic [mem_dw-1:0] exp, input logic hold);
   int waited;
   waited = 0;
   @(posedge clk);
   #1;
   cyc      = 1'b1;
   stb      = 1'b1;
   we       = wr;
   adr      = a;
   sel      = s;
   dat_w    = d;
   rd_chk   = ~wr;    // only reads compare dat_r
   rd_exp   = exp;
   bus_held = hold;   // request sits behind a BIST run
   do begin
      @(negedge clk);  // ack settled mid-cycle
      waited++;
      if (waited > ack_limit) stop_run("bus cycle never got an ack");
   end while (!ack);
   @(posedge clk);
   #1;
   cyc      = 1'b0;
   stb      = 1'b0;
   we       = 1'b0;
   rd_chk   = 1'b0;
   bus_held = 1'b0;
endtask

task automatic bus_write(input logic [mem_aw-1:0] a, input logic [mem_sel_w-1:0] s,
                         input logic [mem_dw-1:0] d);
   bus_cycle(1'b1, a, s, d, '0, 1'b0);
   if (!shutdown) shadow_write(a, s, d);  // dropped while powered off
endtask

task automatic bus_read(input logic [mem_aw-1:0] a, input logic hold);
   bus_cycle(1'b0, a, '1, '0, shutdown ? '0 : shadow[a], hold);
endtask

task automatic set_shutdown(input logic v);
   @(posedge clk);
   #1;
   shutdown = v;
endtask

// start pulse, then wait for the end-of-run pulse
task automatic run_bist();
   int waited;
   waited = 0;
   @(posedge clk);
   #1;
   start_bist = 1'b1;
   for (int i = 0; i < mem_depth; i++) shadow[i] = '0;  // run leaves all zero
   @(posedge clk);
   #1;
   start_bist = 1'b0;
   do begin
      @(negedge clk);
      waited++;
      if (waited > bist_cycles + 16) stop_run("BIST run never raised bist_done");
   end while (!bist_done);
endtask

`endif

// ==== tests/tb_mem_subsys.sv ====
/*
 * Testbench for the SRAM subsystem: bus timing, byte selects, shutdown, BIST.
 * Concurrent assertions check everything; the first failure stops the run.
 * Assumes a fault-free array, so bist_fail must never rise.
 */

`timescale 1ns/1ps

module tb_mem_subsys
   import mem_pkg::*;
();

   localparam int clk_period  = 8;
   localparam int n_full      = 24;                  // full-word writes
   localparam int n_part      = 24;                  // byte-select writes
   localparam int n_sd        = 8;                   // accesses under shutdown
   localparam int n_after     = 16;                  // extra reads after BIST
   localparam int bist_cycles = 4 * mem_depth + 2;   // start sample to done
   localparam int ack_limit   = bist_cycles + 16;
   localparam int bus_ops     = 3 * n_full + 2 * n_part + 3 * n_sd + 1 + n_after;
   localparam int watchdog_cycles = (bus_ops * 4 + bist_cycles + 16) * 3 / 2;

   logic                 clk = 1'b0;
   logic                 rst_n;
   logic                 cyc;
   logic                 stb;
   logic                 we;
   logic [mem_aw-1:0]    adr;
   logic [mem_sel_w-1:0] sel;
   logic [mem_dw-1:0]    dat_w;
   logic [mem_dw-1:0]    dat_r;
   logic                 ack;
   logic                 start_bist;
   logic                 shutdown;
   logic                 bist_done;
   logic                 bist_fail;

   logic [31:0]       lfsr;                 // random state
   logic [mem_dw-1:0] shadow [mem_depth];   // predicted array contents
   logic [mem_aw-1:0] used_addr [$];        // addresses with known data
   logic              rd_chk;               // current cycle is a checked read
   logic [mem_dw-1:0] rd_exp;               // its expected dat_r
   logic              bus_held;             // cycle issued during BIST
   int                cyc_age;              // edges since stb was first sampled
   logic              bist_run;             // start seen, done not yet
   int                bist_cnt;             // edges since start was sampled

   mem_subsys_top mem_subsys_top_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .cyc        (cyc),
      .stb        (stb),
      .we         (we),
      .adr        (adr),
      .sel        (sel),
      .dat_w      (dat_w),
      .dat_r      (dat_r),
      .ack        (ack),
      .start_bist (start_bist),
      .shutdown   (shutdown),
      .bist_done  (bist_done),
      .bist_fail  (bist_fail)
   );

   always #(clk_period / 2) clk = ~clk;

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("CHECKS FAILED");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic value_error(input string sig, input logic [31:0] exp, input logic [31:0] act);
      stop_run($sformatf("[ERROR] %0t ns %s expected %0h actual %0h", $time, sig, exp, act));
   endtask

   `include "tb_tasks.svh"

   //##########################################################################
   // reference timing from the bus and BIST rules
   //##########################################################################

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cyc_age <= 0;
      end else if (cyc && stb && !ack) begin
         cyc_age <= cyc_age + 1;   // waiting for ack
      end else begin
         cyc_age <= 0;
      end
   end

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         bist_run <= 1'b0;
         bist_cnt <= 0;
      end else if (!bist_run && start_bist) begin
         bist_run <= 1'b1;          // start taken in idle
         bist_cnt <= 0;
      end else if (bist_run) begin
         bist_cnt <= bist_cnt + 1;
         if (bist_done) bist_run <= 1'b0;
      end
   end

   //##########################################################################
   // checks
   //##########################################################################

   a_reset: assert property (@(posedge clk) !rst_n |-> (!ack && !bist_done && !bist_fail))
      else stop_run("ack or a BIST flag is high during reset");
   a_ack_cyc: assert property (@(posedge clk) disable iff (!rst_n) ack |-> (cyc && stb))
      else stop_run("ack seen outside a bus cycle");
   a_ack_once: assert property (@(posedge clk) disable iff (!rst_n) ack |-> !$past(ack))
      else stop_run("ack stayed high for more than one cycle");
   a_ack_lat: assert property (@(posedge clk) disable iff (!rst_n)
                               (ack && !bus_held) |-> (cyc_age == 2))
      else value_error("ack latency", 2, $sampled(cyc_age));
   a_ack_late: assert property (@(posedge clk) disable iff (!rst_n)
                                (cyc && stb && !bus_held) |-> (cyc_age <= 2))
      else stop_run("no ack 2 cycles after stb was sampled");
   a_rd_data: assert property (@(posedge clk) disable iff (!rst_n)
                               (ack && rd_chk) |-> (dat_r == rd_exp))
      else value_error("dat_r", rd_exp, $sampled(dat_r));
   a_ack_bist: assert property (@(posedge clk) disable iff (!rst_n) ack |-> !bist_run)
      else stop_run("bus cycle acked while the BIST run was active");
   a_done_time: assert property (@(posedge clk) disable iff (!rst_n)
                                 bist_done |-> (bist_run && bist_cnt == bist_cycles))
      else value_error("bist_done cycle", bist_cycles, $sampled(bist_cnt));
   a_done_late: assert property (@(posedge clk) disable iff (!rst_n)
                                 bist_run |-> (bist_cnt <= bist_cycles))
      else stop_run("bist_done missing at the end of the run");
   a_no_fail: assert property (@(posedge clk) disable iff (!rst_n) !bist_fail)
      else value_error("bist_fail", 0, 1);

   initial begin : watchdog
      #(watchdog_cycles * clk_period);
      stop_run("watchdog expired, the run is stuck");
   end

   //##########################################################################
   // stimulus
   //##########################################################################

   initial begin : main_seq
      logic [mem_aw-1:0] a;
      logic [mem_dw-1:0] d;
      lfsr       = 32'he599_e769;
      rst_n      = 1'b0;
      cyc        = 1'b0;
      stb        = 1'b0;
      we         = 1'b0;
      adr        = '0;
      sel        = '0;
      dat_w      = '0;
      start_bist = 1'b0;
      shutdown   = 1'b0;
      rd_chk     = 1'b0;
      rd_exp     = '0;
      bus_held   = 1'b0;
      repeat (3) @(posedge clk);
      #1;
      rst_n = 1'b1;

      for (int i = 0; i < n_full; i++) begin   // full words, then read back
         a = mem_aw'(rand_bits(mem_aw));
         used_addr.push_back(a);
         bus_write(a, '1, rand_bits(mem_dw));
      end
      foreach (used_addr[i]) bus_read(used_addr[i], 1'b0);

      for (int i = 0; i < n_part; i++) begin   // random byte selects
         a = used_addr[rand_bits(5) % used_addr.size()];
         d = rand_bits(mem_dw);
         bus_write(a, mem_sel_w'(rand_bits(mem_sel_w)), d);
         bus_read(a, 1'b0);
      end

      set_shutdown(1'b1);
      for (int i = 0; i < n_sd; i++) begin     // reads zero, writes dropped
         bus_read(used_addr[i], 1'b0);
         bus_write(used_addr[i], '1, rand_bits(mem_dw));
      end
      set_shutdown(1'b0);
      for (int i = 0; i < n_sd; i++) bus_read(used_addr[i], 1'b0);

      fork
         run_bist();
         begin
            repeat (20) @(posedge clk);         // lands mid-run
            bus_read(used_addr[0], 1'b1);
         end
      join

      foreach (used_addr[i]) bus_read(used_addr[i], 1'b0);
      for (int i = 0; i < n_after; i++) bus_read(mem_aw'(rand_bits(mem_aw)), 1'b0);

      repeat (2) @(posedge clk);
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

// ==== sim.f ====
+incdir+tests
design/mem_pkg.sv
design/mem_ram.sv
design/mem_sp.sv
design/mem_bist.sv
design/wb_mem_slave.sv
design/mem_subsys_top.sv
tests/tb_mem_subsys.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the run from sim.log.
# Exits non-zero when the build fails or the pass line is missing from the log.

cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert --timescale 1ns/1ps \
   -f sim.f --top-module tb_mem_subsys &&
{ ./obj_dir/Vtb_mem_subsys > sim.log 2>&1 || true; } &&
cat sim.log &&
grep -q "ALL CHECKS PASSED" sim.log &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed, see sim.log"; exit 1; }
